// File: Makefile
TOP = tbLoadTop

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+.
loadPkg.sv
regFile.sv
pcFile.sv
operandLoad.sv
intAlu.sv
loadTop.sv
tbLoadTop.sv

// File: intAlu.sv
`timescale 1ns/1ps
`default_nettype none

module intAlu import loadPkg::*; (
    input  wire clk,
    input  wire rst,

    input  wire EX_UOp exUOp,
    input  wire enable,

    // Same-cycle result for dependents
    output logic zcValid,
    output Tag zcTag,
    output logic [31:0] zcResult,

    // Registered writeback
    output logic wbValid,
    output RES_UOp wbUOp
);

    always_comb begin
        zcValid = exUOp.valid && enable;
        zcTag = exUOp.tagDst;
        case (IntOp'(exUOp.opcode[2:0]))
            ADD: zcResult = exUOp.srcA + exUOp.srcB;
            SUB: zcResult = exUOp.srcA - exUOp.srcB;
            AND: zcResult = exUOp.srcA & exUOp.srcB;
            OR:  zcResult = exUOp.srcA | exUOp.srcB;
            XOR: zcResult = exUOp.srcA ^ exUOp.srcB;
            default: zcResult = 32'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= zcValid;
        end
    end

    // Payload only, valid above
    always_ff @(posedge clk) begin
        if (zcValid) begin
            wbUOp.result <= zcResult;
            wbUOp.tagDst <= exUOp.tagDst;
            wbUOp.sqN <= exUOp.sqN;
        end
    end

endmodule

`default_nettype wire

// File: loadPkg.sv
`default_nettype none

package loadPkg;

    // Physical register tag, bits 5:0 address the register file
    typedef logic [6:0] Tag;

    // Sequence number, compared by signed difference
    typedef logic [6:0] SqN;

    typedef logic [2:0] FetchID_t;
    typedef logic [7:0] BHist_t;

    // Tag of the hardwired zero register
    localparam Tag zeroTag = 7'h7f;

    // Order matters, it sets the enableXU bit position
    typedef enum logic [2:0] {
        FU_INT,
        FU_LSU,
        FU_ST,
        FU_MUL,
        FU_DIV,
        FU_FPU
    } FuncUnit;

    // ALU operation in the low bits of opcode
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR
    } IntOp;

    typedef struct packed {
        logic predicted;
        logic taken;
        logic isJump;
    } BranchPredInfo;

    typedef struct packed {
        logic [30:0] pc;
        logic [1:0] branchPos;
        BHist_t hist;
        BranchPredInfo bpi;
    } PCFileEntry;

    // Micro-op as issued
    typedef struct packed {
        logic [31:0] imm;
        Tag tagA;
        Tag tagB;
        Tag tagDst;
        logic [4:0] nmDst;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
        logic [5:0] opcode;
        FetchID_t fetchID;
        logic [1:0] fetchOffs;
        logic compressed;
        logic immB;
        FuncUnit fu;
    } R_UOp;

    // Micro-op with operands, sent to execute
    typedef struct packed {
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [31:0] imm;
        logic [31:0] pc;
        Tag tagDst;
        logic [4:0] nmDst;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
        logic [5:0] opcode;
        FetchID_t fetchID;
        BHist_t history;
        BranchPredInfo bpi;
        logic compressed;
        logic valid;
    } EX_UOp;

    typedef struct packed {
        logic [31:0] result;
        Tag tagDst;
        SqN sqN;
    } RES_UOp;

endpackage

`default_nettype wire

// File: loadTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "load_config.svh"

module loadTop import loadPkg::*; (
    input  wire clk,
    input  wire rst,

    input  wire uopValid [`LD_NUM_PORTS-1:0],
    input  wire R_UOp uop [`LD_NUM_PORTS-1:0],
    input  wire stall [`LD_NUM_PORTS-1:0],

    // Stands in for load and multiply results
    input  wire extWbValid,
    input  wire RES_UOp extWbUOp,

    input  wire invalidate,
    input  wire SqN invalidateSqN,

    input  wire pcWrEn,
    input  wire FetchID_t pcWrAddr,
    input  wire PCFileEntry pcWrData,

    output logic [`LD_NUM_XUS-1:0] enableXU [`LD_NUM_PORTS-1:0],
    output FuncUnit funcUnit [`LD_NUM_PORTS-1:0],
    output EX_UOp exUOp [`LD_NUM_PORTS-1:0],

    output logic wbValid [`LD_NUM_WBS-1:0],
    output RES_UOp wbUOp [`LD_NUM_WBS-1:0]
);

    FetchID_t pcReadAddr [`LD_NUM_PORTS-1:0];
    PCFileEntry pcReadData [`LD_NUM_PORTS-1:0];
    logic [5:0] rfReadAddr [2*`LD_NUM_PORTS-1:0];
    logic [31:0] rfReadData [2*`LD_NUM_PORTS-1:0];

    logic zcValid [`LD_NUM_ZC-1:0];
    Tag zcTag [`LD_NUM_ZC-1:0];
    logic [31:0] zcResult [`LD_NUM_ZC-1:0];

    logic aluWbValid;
    RES_UOp aluWbUOp;

    // ALU on writeback port 0, external source on port 1
    always_comb begin
        wbValid[0] = aluWbValid;
        wbUOp[0] = aluWbUOp;
        wbValid[1] = extWbValid;
        wbUOp[1] = extWbUOp;
    end

    pcFile pcFile_i (
        .clk(clk),
        .wrEn(pcWrEn),
        .wrAddr(pcWrAddr),
        .wrData(pcWrData),
        .rdAddr(pcReadAddr),
        .rdData(pcReadData)
    );

    regFile regFile_i (
        .clk(clk),
        .rst(rst),
        .rdAddr(rfReadAddr),
        .rdData(rfReadData),
        .wbValid(wbValid),
        .wbUOp(wbUOp)
    );

    operandLoad operandLoad_i (
        .clk(clk),
        .rst(rst),
        .uopValid(uopValid),
        .uop(uop),
        .stall(stall),
        .wbValid(wbValid),
        .wbUOp(wbUOp),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .zcValid(zcValid),
        .zcTag(zcTag),
        .zcResult(zcResult),
        .pcReadAddr(pcReadAddr),
        .pcReadData(pcReadData),
        .rfReadAddr(rfReadAddr),
        .rfReadData(rfReadData),
        .enableXU(enableXU),
        .funcUnit(funcUnit),
        .exUOp(exUOp)
    );

    // Integer ALU sits on port 0, enable bit 0 is FU_INT
    intAlu intAlu_i (
        .clk(clk),
        .rst(rst),
        .exUOp(exUOp[0]),
        .enable(enableXU[0][0]),
        .zcValid(zcValid[0]),
        .zcTag(zcTag[0]),
        .zcResult(zcResult[0]),
        .wbValid(aluWbValid),
        .wbUOp(aluWbUOp)
    );

endmodule

`default_nettype wire

// File: load_config.svh
`ifndef LOAD_CONFIG_SVH
`define LOAD_CONFIG_SVH

// Issue ports into the operand-load stage
`define LD_NUM_PORTS 2

// Writeback ports, 0 is the integer ALU and 1 comes from outside
`define LD_NUM_WBS 2

// Zero-cycle forwards
`define LD_NUM_ZC 1

// Execution units, one enable bit each
`define LD_NUM_XUS 6

`define LD_RF_DEPTH 64
`define LD_PCF_DEPTH 8

`endif

// File: operandLoad.sv
`timescale 1ns/1ps
`default_nettype none

`include "load_config.svh"

module operandLoad import loadPkg::*; (
    input  wire clk,
    input  wire rst,

    // Issue side
    input  wire uopValid [`LD_NUM_PORTS-1:0],
    input  wire R_UOp uop [`LD_NUM_PORTS-1:0],
    input  wire stall [`LD_NUM_PORTS-1:0],

    // Writeback snoop
    input  wire wbValid [`LD_NUM_WBS-1:0],
    input  wire RES_UOp wbUOp [`LD_NUM_WBS-1:0],

    input  wire invalidate,
    input  wire SqN invalidateSqN,

    // Zero-cycle forward
    input  wire zcValid [`LD_NUM_ZC-1:0],
    input  wire Tag zcTag [`LD_NUM_ZC-1:0],
    input  wire [31:0] zcResult [`LD_NUM_ZC-1:0],

    output FetchID_t pcReadAddr [`LD_NUM_PORTS-1:0],
    input  wire PCFileEntry pcReadData [`LD_NUM_PORTS-1:0],

    output logic [5:0] rfReadAddr [2*`LD_NUM_PORTS-1:0],
    input  wire [31:0] rfReadData [2*`LD_NUM_PORTS-1:0],

    // Execute side
    output logic [`LD_NUM_XUS-1:0] enableXU [`LD_NUM_PORTS-1:0],
    output FuncUnit funcUnit [`LD_NUM_PORTS-1:0],
    output EX_UOp exUOp [`LD_NUM_PORTS-1:0]
);

    localparam logic [`LD_NUM_XUS-1:0] xuOne = 1;

    // Operand k belongs to port k mod ports, the upper half are B operands
    Tag opTag [2*`LD_NUM_PORTS-1:0];
    logic [31:0] opValue [2*`LD_NUM_PORTS-1:0];

    logic [31:0] srcB [`LD_NUM_PORTS-1:0];
    logic [31:0] pcRebuilt [`LD_NUM_PORTS-1:0];
    BHist_t histRebuilt [`LD_NUM_PORTS-1:0];
    BranchPredInfo bpiRebuilt [`LD_NUM_PORTS-1:0];
    logic accept [`LD_NUM_PORTS-1:0];
    logic dropHeld [`LD_NUM_PORTS-1:0];

    // True when a is younger than b
    function automatic logic isYounger(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    always_comb begin
        for (int i = 0; i < `LD_NUM_PORTS; i++) begin
            opTag[i] = uop[i].tagA;
            opTag[i + `LD_NUM_PORTS] = uop[i].tagB;
            pcReadAddr[i] = uop[i].fetchID;
        end
        for (int k = 0; k < 2 * `LD_NUM_PORTS; k++) begin
            rfReadAddr[k] = opTag[k][5:0];
        end
    end

    // Register file, then writeback snoop, then zero-cycle forward, then zero tag
    always_comb begin
        for (int k = 0; k < 2 * `LD_NUM_PORTS; k++) begin
            opValue[k] = rfReadData[k];
            for (int j = 0; j < `LD_NUM_WBS; j++) begin
                if (wbValid[j] && wbUOp[j].tagDst == opTag[k]) begin
                    opValue[k] = wbUOp[j].result;
                end
            end
            for (int j = 0; j < `LD_NUM_ZC; j++) begin
                if (zcValid[j] && zcTag[j] == opTag[k]) begin
                    opValue[k] = zcResult[j];
                end
            end
            if (opTag[k] == zeroTag) begin
                opValue[k] = 32'b0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `LD_NUM_PORTS; i++) begin
            srcB[i] = uop[i].immB ? uop[i].imm : opValue[i + `LD_NUM_PORTS];

            // fetchOffs points at the last halfword of the instruction
            pcRebuilt[i] = {1'b0, pcReadData[i].pc[30:3], uop[i].fetchOffs, 1'b0}
                - (uop[i].compressed ? 32'd0 : 32'd2);

            // Past a predicted branch the history already holds its outcome
            if (pcReadData[i].bpi.predicted && !pcReadData[i].bpi.isJump
                    && uop[i].fetchOffs > pcReadData[i].branchPos) begin
                histRebuilt[i] = {pcReadData[i].hist[$bits(BHist_t)-2:0],
                                  pcReadData[i].bpi.taken};
            end else begin
                histRebuilt[i] = pcReadData[i].hist;
            end

            bpiRebuilt[i] = (uop[i].fetchOffs == pcReadData[i].branchPos)
                ? pcReadData[i].bpi : '0;

            accept[i] = uopValid[i] && !stall[i]
                && !(invalidate && isYounger(uop[i].sqN, invalidateSqN));
            dropHeld[i] = invalidate && exUOp[i].valid
                && isYounger(exUOp[i].sqN, invalidateSqN);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LD_NUM_PORTS; i++) begin
                exUOp[i].valid <= 1'b0;
                enableXU[i] <= '0;
                funcUnit[i] <= FU_INT;
            end
        end else begin
            for (int i = 0; i < `LD_NUM_PORTS; i++) begin
                if (accept[i]) begin
                    exUOp[i].srcA <= opValue[i];
                    exUOp[i].srcB <= srcB[i];
                    exUOp[i].imm <= uop[i].imm;
                    exUOp[i].pc <= pcRebuilt[i];
                    exUOp[i].tagDst <= uop[i].tagDst;
                    exUOp[i].nmDst <= uop[i].nmDst;
                    exUOp[i].sqN <= uop[i].sqN;
                    exUOp[i].loadSqN <= uop[i].loadSqN;
                    exUOp[i].storeSqN <= uop[i].storeSqN;
                    exUOp[i].opcode <= uop[i].opcode;
                    exUOp[i].fetchID <= uop[i].fetchID;
                    exUOp[i].history <= histRebuilt[i];
                    exUOp[i].bpi <= bpiRebuilt[i];
                    exUOp[i].compressed <= uop[i].compressed;
                    exUOp[i].valid <= 1'b1;
                    funcUnit[i] <= uop[i].fu;
                    // One-hot in FuncUnit order
                    enableXU[i] <= xuOne << uop[i].fu;
                end else if (!stall[i] || dropHeld[i]) begin
                    exUOp[i].valid <= 1'b0;
                    enableXU[i] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: pcFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "load_config.svh"

module pcFile import loadPkg::*; (
    input  wire clk,

    // Fetch side write
    input  wire wrEn,
    input  wire FetchID_t wrAddr,
    input  wire PCFileEntry wrData,

    // One read per issue port
    input  wire FetchID_t rdAddr [`LD_NUM_PORTS-1:0],
    output PCFileEntry rdData [`LD_NUM_PORTS-1:0]
);

    // Fetch-block context, indexed by fetch ID
    PCFileEntry entries [`LD_PCF_DEPTH-1:0];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            entries[wrAddr] <= wrData;
        end
    end

    always_comb begin
        for (int i = 0; i < `LD_NUM_PORTS; i++) begin
            rdData[i] = entries[rdAddr[i]];
        end
    end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "load_config.svh"

module regFile import loadPkg::*; (
    input  wire clk,
    input  wire rst,

    // Two reads per issue port, tagA reads first, then tagB
    input  wire [5:0] rdAddr [2*`LD_NUM_PORTS-1:0],
    output logic [31:0] rdData [2*`LD_NUM_PORTS-1:0],

    input  wire wbValid [`LD_NUM_WBS-1:0],
    input  wire RES_UOp wbUOp [`LD_NUM_WBS-1:0]
);

    logic [31:0] regs [`LD_RF_DEPTH-1:0];

    // Reads are combinational, no write-through
    always_comb begin
        for (int i = 0; i < 2 * `LD_NUM_PORTS; i++) begin
            rdData[i] = regs[rdAddr[i]];
        end
    end

    // Later writeback port wins on the same address
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int j = 0; j < `LD_NUM_WBS; j++) begin
                // Zero register is never stored
                if (wbValid[j] && wbUOp[j].tagDst != zeroTag) begin
                    regs[wbUOp[j].tagDst[5:0]] <= wbUOp[j].result;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tbLoadTasks.svh
`ifndef TB_LOAD_TASKS_SVH
`define TB_LOAD_TASKS_SVH

task automatic testReset();
    for (int p = 0; p < `LD_NUM_PORTS; p++) begin
        checkFlag($sformatf("exUOp[%0d].valid", p), exUOp[p].valid, 1'b0);
        checkEnable($sformatf("enableXU[%0d]", p), enableXU[p], '0);
        checkFunc($sformatf("funcUnit[%0d]", p), funcUnit[p], FU_INT);
    end
    for (int q = 0; q < `LD_NUM_WBS; q++) begin
        checkFlag($sformatf("wbValid[%0d]", q), wbValid[q], 1'b0);
    end
endtask

task automatic testRegFile();
    R_UOp u;
    logic [31:0] va;
    logic [31:0] vb;
    va = $urandom;
    vb = $urandom;
    // Register 63 holds a nonzero value that the zero tag must hide
    writeReg(7'h3f, $urandom | 32'h1);
    writeReg(7'h05, va);
    writeReg(7'h26, vb);
    u = newUop(FU_LSU, 7'd3);
    u.tagA = 7'h05;
    u.tagB = 7'h26;
    issue(1, u);
    waitExValid(1);
    checkExUOp("exUOp[1]", exUOp[1], expectEx(u, va, vb));
    // Zero tag reads 0 and immB replaces the B register
    u = newUop(FU_LSU, 7'd4);
    u.tagB = 7'h26;
    u.immB = 1'b1;
    issue(1, u);
    waitExValid(1);
    checkExUOp("exUOp[1]", exUOp[1], expectEx(u, 32'b0, vb));
endtask

task automatic testForwarding();
    R_UOp u;
    R_UOp d;
    RES_UOp w;
    logic [31:0] sum;
    writeReg(7'h05, $urandom);
    w.result = $urandom;
    w.tagDst = 7'h05;
    w.sqN = 7'd8;
    u = newUop(FU_DIV, 7'd9);
    u.tagA = 7'h05;
    // Snooped writeback beats the stale register
    @(posedge clk);
    extWbValid <= 1'b1;
    extWbUOp <= w;
    setPort(1, 1'b1, u);
    @(posedge clk);
    extWbValid <= 1'b0;
    setPort(1, 1'b0, u);
    waitExValid(1);
    checkExUOp("exUOp[1]", exUOp[1], expectEx(u, w.result, 32'b0));
    u = newUop(FU_INT, 7'd10);
    u.tagA = 7'h05;
    u.immB = 1'b1;
    u.tagDst = 7'h15;
    sum = w.result + u.imm;
    d = newUop(FU_MUL, 7'd11);
    d.tagA = 7'h15;
    // Dependent follows the ALU op one cycle later
    @(posedge clk);
    setPort(0, 1'b1, u);
    @(posedge clk);
    setPort(0, 1'b0, u);
    setPort(1, 1'b1, d);
    @(posedge clk);
    setPort(1, 1'b0, d);
    waitExValid(1);
    checkExUOp("exUOp[1]", exUOp[1], expectEx(d, sum, 32'b0));
    w.result = sum;
    w.tagDst = 7'h15;
    w.sqN = 7'd10;
    checkFlag("wbValid[0]", wbValid[0], 1'b1);
    checkWb("wbUOp[0]", wbUOp[0], w);
endtask

task automatic testPcRebuild();
    PCFileEntry e;
    R_UOp u;
    e.pc = 31'($urandom);
    e.branchPos = 2'd1;
    e.hist = BHist_t'($urandom);
    e.bpi.predicted = 1'b1;
    e.bpi.taken = 1'b1;
    e.bpi.isJump = 1'b0;
    writePc(3'd5, e);
    // Offsets before, at and past the branch
    // Odd steps are compressed
    for (int k = 0; k < 6; k++) begin
        u = newUop(FU_ST, SqN'(20 + k));
        u.fetchID = 3'd5;
        u.fetchOffs = 2'(k / 2);
        u.compressed = 1'(k % 2);
        issue(k % 2, u);
        waitExValid(k % 2);
        checkExUOp($sformatf("exUOp[%0d]", k % 2), exUOp[k % 2], expectEx(u, 32'b0, 32'b0));
    end
endtask

task automatic testEnable();
    R_UOp u;
    FuncUnit fu;
    for (int p = 0; p < `LD_NUM_PORTS; p++) begin
        for (int f = 0; f < `LD_NUM_XUS; f++) begin
            fu = FuncUnit'(f);
            u = newUop(fu, SqN'(30 + f));
            issue(p, u);
            waitExValid(p);
            checkEnable($sformatf("enableXU[%0d]", p), enableXU[p], 6'b1 << f);
            checkFunc($sformatf("funcUnit[%0d]", p), funcUnit[p], fu);
        end
    end
endtask

task automatic issueInvalidated(input R_UOp u, input SqN limit);
    @(posedge clk);
    setPort(1, 1'b1, u);
    invalidate <= 1'b1;
    invalidateSqN <= limit;
    @(posedge clk);
    setPort(1, 1'b0, u);
    invalidate <= 1'b0;
endtask

task automatic testStallInvalidate();
    R_UOp a;
    R_UOp b;
    a = newUop(FU_LSU, 7'd40);
    b = newUop(FU_MUL, 7'd41);
    issue(1, a);
    // Stall from the taking edge on while a newer micro-op waits
    stall[1] <= 1'b1;
    setPort(1, 1'b1, b);
    waitExValid(1);
    repeat (2) @(negedge clk);
    checkExUOp("exUOp[1]", exUOp[1], expectEx(a, 32'b0, 32'b0));
    checkEnable("enableXU[1]", enableXU[1], 6'b1 << FU_LSU);
    @(posedge clk);
    setPort(1, 1'b0, b);
    invalidate <= 1'b1;
    invalidateSqN <= 7'd35;
    @(posedge clk);
    invalidate <= 1'b0;
    stall[1] <= 1'b0;
    @(negedge clk);
    checkFlag("exUOp[1].valid", exUOp[1].valid, 1'b0);
    checkEnable("enableXU[1]", enableXU[1], '0);
    // Younger incoming micro-op is dropped
    a = newUop(FU_ST, 7'd50);
    issueInvalidated(a, 7'd45);
    @(negedge clk);
    checkFlag("exUOp[1].valid", exUOp[1].valid, 1'b0);
    checkEnable("enableXU[1]", enableXU[1], '0);
    a = newUop(FU_ST, 7'd44);
    issueInvalidated(a, 7'd45);
    waitExValid(1);
    checkExUOp("exUOp[1]", exUOp[1], expectEx(a, 32'b0, 32'b0));
endtask

`endif

// File: tbLoadTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "load_config.svh"

module tbLoadTop import loadPkg::*; ();

    logic clk;
    logic rst;
    logic uopValid [`LD_NUM_PORTS-1:0];
    R_UOp uop [`LD_NUM_PORTS-1:0];
    logic stall [`LD_NUM_PORTS-1:0];
    logic extWbValid;
    RES_UOp extWbUOp;
    logic invalidate;
    SqN invalidateSqN;
    logic pcWrEn;
    FetchID_t pcWrAddr;
    PCFileEntry pcWrData;
    logic [`LD_NUM_XUS-1:0] enableXU [`LD_NUM_PORTS-1:0];
    FuncUnit funcUnit [`LD_NUM_PORTS-1:0];
    EX_UOp exUOp [`LD_NUM_PORTS-1:0];
    logic wbValid [`LD_NUM_WBS-1:0];
    RES_UOp wbUOp [`LD_NUM_WBS-1:0];

    // What the PC file should hold
    PCFileEntry pcModel [`LD_PCF_DEPTH-1:0];
    int checkCount;
    int errorCount;

    loadTop loadTop_i (
        .clk(clk),
        .rst(rst),
        .uopValid(uopValid),
        .uop(uop),
        .stall(stall),
        .extWbValid(extWbValid),
        .extWbUOp(extWbUOp),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .pcWrEn(pcWrEn),
        .pcWrAddr(pcWrAddr),
        .pcWrData(pcWrData),
        .enableXU(enableXU),
        .funcUnit(funcUnit),
        .exUOp(exUOp),
        .wbValid(wbValid),
        .wbUOp(wbUOp)
    );

    always #2 clk = ~clk;

    task automatic checkExUOp(input string name, input EX_UOp got, input EX_UOp exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkWb(input string name, input RES_UOp got, input RES_UOp exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkEnable(input string name, input logic [`LD_NUM_XUS-1:0] got,
                               input logic [`LD_NUM_XUS-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkFunc(input string name, input FuncUnit got, input FuncUnit exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Idle micro-op with every tag on the zero register
    function automatic R_UOp newUop(input FuncUnit fu, input SqN sqN);
        R_UOp u;
        u.imm = $urandom;
        u.tagA = zeroTag;
        u.tagB = zeroTag;
        u.tagDst = zeroTag;
        u.nmDst = 5'($urandom);
        u.sqN = sqN;
        u.loadSqN = SqN'($urandom);
        u.storeSqN = SqN'($urandom);
        u.opcode = 6'(ADD);
        u.fetchID = FetchID_t'($urandom);
        u.fetchOffs = 2'($urandom);
        u.compressed = 1'($urandom);
        u.immB = 1'b0;
        u.fu = fu;
        return u;
    endfunction

    function automatic PCFileEntry randomEntry();
        PCFileEntry e;
        e.pc = 31'($urandom);
        e.branchPos = 2'($urandom);
        e.hist = BHist_t'($urandom);
        e.bpi = BranchPredInfo'(3'($urandom));
        return e;
    endfunction

    function automatic EX_UOp expectEx(input R_UOp u, input logic [31:0] a,
                                       input logic [31:0] b);
        PCFileEntry e;
        EX_UOp x;
        e = pcModel[u.fetchID];
        x.srcA = a;
        x.srcB = u.immB ? u.imm : b;
        x.imm = u.imm;
        // Block base plus halfword offset
        x.pc = (32'(e.pc[30:3]) << 3) + (32'(u.fetchOffs) << 1);
        if (!u.compressed) begin
            // Back one halfword for a full-size instruction
            x.pc = x.pc - 32'd2;
        end
        x.tagDst = u.tagDst;
        x.nmDst = u.nmDst;
        x.sqN = u.sqN;
        x.loadSqN = u.loadSqN;
        x.storeSqN = u.storeSqN;
        x.opcode = u.opcode;
        x.fetchID = u.fetchID;
        if (e.bpi.predicted && !e.bpi.isJump && u.fetchOffs > e.branchPos) begin
            x.history = {e.hist[6:0], e.bpi.taken};
        end else begin
            x.history = e.hist;
        end
        x.bpi = (u.fetchOffs == e.branchPos) ? e.bpi : '0;
        x.compressed = u.compressed;
        x.valid = 1'b1;
        return x;
    endfunction

    task automatic setPort(input int p, input logic v, input R_UOp u);
        if (p == 0) begin
            uopValid[0] <= v;
            uop[0] <= u;
        end else begin
            uopValid[1] <= v;
            uop[1] <= u;
        end
    endtask

    // Ends on the edge that takes the micro-op
    task automatic issue(input int p, input R_UOp u);
        @(posedge clk);
        setPort(p, 1'b1, u);
        @(posedge clk);
        setPort(p, 1'b0, u);
    endtask

    task automatic writeReg(input Tag tag, input logic [31:0] value);
        RES_UOp w;
        w.result = value;
        w.tagDst = tag;
        w.sqN = 7'd0;
        @(posedge clk);
        extWbValid <= 1'b1;
        extWbUOp <= w;
        // External writeback shows on port 1 of the writeback array
        @(negedge clk);
        checkFlag("wbValid[1]", wbValid[1], 1'b1);
        checkWb("wbUOp[1]", wbUOp[1], w);
        @(posedge clk);
        extWbValid <= 1'b0;
    endtask

    task automatic writePc(input FetchID_t addr, input PCFileEntry e);
        @(posedge clk);
        pcWrEn <= 1'b1;
        pcWrAddr <= addr;
        pcWrData <= e;
        @(posedge clk);
        pcWrEn <= 1'b0;
        pcModel[addr] = e;
    endtask

    task automatic waitExValid(input int p);
        int n;
        n = 0;
        @(negedge clk);
        while (!exUOp[p].valid && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (!exUOp[p].valid) begin
            errorCount++;
            $display("Port %0d sent no valid micro-op to execute in time", p);
        end
    endtask

    `include "tbLoadTasks.svh"

    initial begin
        void'($urandom(32'h5198));
        checkCount = 0;
        errorCount = 0;
        clk = 1'b0;
        rst <= 1'b1;
        setPort(0, 1'b0, '0);
        setPort(1, 1'b0, '0);
        stall[0] <= 1'b0;
        stall[1] <= 1'b0;
        extWbValid <= 1'b0;
        extWbUOp <= '0;
        invalidate <= 1'b0;
        invalidateSqN <= '0;
        pcWrEn <= 1'b0;
        pcWrAddr <= '0;
        pcWrData <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        testReset();
        for (int i = 0; i < `LD_PCF_DEPTH; i++) begin
            writePc(FetchID_t'(i), randomEntry());
        end
        testRegFile();
        testForwarding();
        testPcRebuild();
        testEnable();
        testStallInvalidate();
        $display("Checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
